//--- logic/motor_pkg.sv
// motor_pkg: bus widths, channel addressing, register offsets, field positions, reset values
package motor_pkg;

    // wishbone bus
    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 32;

    // address split, upper nibble picks the channel
    localparam int CH_SEL_MSB = 7;
    localparam int CH_SEL_LSB = 4;

    // word offsets inside a channel window
    localparam logic [3:0] OFF_DAC_CTRL     = 4'd0;
    localparam logic [3:0] OFF_MOTOR_CONFIG = 4'd1;
    localparam logic [3:0] OFF_MOTOR_SAFETY = 4'd2;
    localparam logic [3:0] OFF_MOTOR_STATUS = 4'd3; // read only

    // dac control word
    localparam int DAC_VALID_BIT   = 31; // setpoint and mode taken only if set
    localparam int DAC_EN_MASK_BIT = 29; // enable field valid
    localparam int DAC_EN_BIT      = 28; // requested amp enable
    localparam int DAC_MODE_LSB    = 24; // mode field sits at 27:24
    localparam int CMD_W           = 16; // setpoint width, bits 15:0

    // control modes
    localparam int MODE_W = 4;
    localparam logic [MODE_W-1:0] MODE_CURRENT = 4'd0; // always allowed
    localparam logic [MODE_W-1:0] MODE_VOLTAGE = 4'd1; // needs the io expander

    // config word, upper byte is read only
    localparam int CFG_WR_W           = 24;
    localparam int CFG_SAFETY_OFF_BIT = 17; // disable_safety
    localparam int CFG_FORCE_F_BIT    = 16; // force_disable_f
    localparam int DELAY_W            = 8;  // delay in ticks, bits 7:0

    // reset values
    localparam logic [CFG_WR_W-1:0] CONFIG_RST = 24'd120;
    localparam logic [WB_DAT_W-1:0] SAFETY_RST = 32'h0000_8418;
    localparam logic [CMD_W-1:0]    CMD_RST    = 16'h8000; // mid-scale zero

endpackage

//--- logic/overcurrent_check.sv
// overcurrent_check: absolute current error, persistence counter, latched trip
`timescale 1ns/1ps

module overcurrent_check
    import motor_pkg::*;
#(
    parameter int TRIP_CYCLES = 8
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic [CMD_W-1:0]  cur_fb,         // measured, offset binary
    input  logic [CMD_W-1:0]  cur_cmd,        // commanded, offset binary
    input  logic [CMD_W-1:0]  cur_lim,        // allowed error
    input  logic [MODE_W-1:0] ctrl_mode,
    input  logic              enable_check,
    input  logic              clear_disable,  // pulse from an enable request
    output logic              safety_disable
);

    localparam int CNT_W = $clog2(TRIP_CYCLES + 1);

    logic [CMD_W-1:0] abs_err;
    logic             check_on;
    logic             over_lim;
    logic [CNT_W-1:0] trip_cnt; // consecutive cycles over the limit

    // offsets cancel in the difference, so plain unsigned math is enough
    assign abs_err = (cur_fb >= cur_cmd) ? (cur_fb - cur_cmd) : (cur_cmd - cur_fb);

    // only meaningful while regulating current
    assign check_on = enable_check && (ctrl_mode == MODE_CURRENT);
    assign over_lim = check_on && (abs_err > cur_lim);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            trip_cnt       <= '0;
            safety_disable <= 1'b0;
        end else if (clear_disable) begin
            trip_cnt       <= '0;
            safety_disable <= 1'b0;
        end else begin
            if (!over_lim) begin
                trip_cnt <= '0;                   // one good cycle restarts the count
            end else if (trip_cnt != CNT_W'(TRIP_CYCLES)) begin
                trip_cnt <= trip_cnt + 1'b1;      // saturates at the trip level
            end
            if (trip_cnt == CNT_W'(TRIP_CYCLES)) begin
                safety_disable <= 1'b1;           // latched until cleared
            end
        end
    end

endmodule

//--- logic/amp_enable_delay.sv
// amp_enable_delay: tick prescaler and enable delay counter for the amp disable pin
`timescale 1ns/1ps

module amp_enable_delay
    import motor_pkg::*;
#(
    parameter int TICK_DIV = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               amp_disable,     // 1 keeps the amp off
    input  logic [DELAY_W-1:0] delay,           // in ticks
    input  logic               bypass,          // no follower op amp to wait for
    output logic               amp_disable_pin
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0]   pre_cnt;
    logic               tick;
    logic [DELAY_W-1:0] en_cnt;

    assign tick = (pre_cnt == PRE_W'(TICK_DIV - 1));

    // free running prescaler
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    // counts ticks after the disable is released
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_cnt <= '0;
        end else if (amp_disable) begin
            en_cnt <= '0;
        end else if (tick && (en_cnt < delay)) begin
            en_cnt <= en_cnt + 1'b1;
        end
    end

    // disabling passes straight through, enabling waits for the count
    assign amp_disable_pin = (bypass || (en_cnt >= delay)) ? amp_disable : 1'b1;

endmodule

//--- logic/motor_channel.sv
// motor_channel: setpoint, mode, enable logic, config and limit registers, status word
`timescale 1ns/1ps

module motor_channel
    import motor_pkg::*;
#(
    parameter int TICK_DIV    = 4,
    parameter int TRIP_CYCLES = 8
) (
    input  logic                clk,
    input  logic                arst_n,

    // register port
    input  logic                wen,       // write strobe for this channel
    input  logic [3:0]          reg_off,
    input  logic [WB_DAT_W-1:0] reg_wdata,
    output logic [WB_DAT_W-1:0] status,
    output logic [WB_DAT_W-1:0] cfg,
    output logic [WB_DAT_W-1:0] safety,

    // board state
    input  logic                ioexp_present,
    input  logic                pwr_enable,
    input  logic                wdog_timeout,
    input  logic                amp_fault,     // active low
    input  logic [CMD_W-1:0]    cur_fb,        // measured current

    // amplifier side
    output logic                amp_disable_pin,
    output logic                amp_disable_f,   // follower op amp disable
    output logic                cur_ctrl,        // 1 current, 0 voltage
    output logic [CMD_W-1:0]    cur_cmd
);

    logic                dac_wen;
    logic                cfg_wen;
    logic                safe_wen;
    logic [MODE_W-1:0]   wr_mode;     // mode field of the write
    logic                mode_ok;
    logic                en_req;      // dac write asking for enable
    logic                safety_disable;
    logic                safety_cond;
    logic                reg_disable;
    logic [MODE_W-1:0]   ctrl_mode;
    logic [CFG_WR_W-1:0] config_reg;
    logic [WB_DAT_W-1:0] safety_reg;
    logic                amp_fault_fb;

    // offset decode, channel already picked by the slave
    assign dac_wen  = wen && (reg_off == OFF_DAC_CTRL);
    assign cfg_wen  = wen && (reg_off == OFF_MOTOR_CONFIG);
    assign safe_wen = wen && (reg_off == OFF_MOTOR_SAFETY);

    assign wr_mode = reg_wdata[DAC_MODE_LSB +: MODE_W];
    // voltage control only with the io expander fitted
    assign mode_ok = (wr_mode == MODE_CURRENT) ||
                     (ioexp_present && (wr_mode == MODE_VOLTAGE));

    assign en_req      = dac_wen & reg_wdata[DAC_EN_MASK_BIT] & reg_wdata[DAC_EN_BIT];
    assign safety_cond = wdog_timeout | safety_disable;

    // setpoint and mode
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd   <= CMD_RST;
            ctrl_mode <= MODE_CURRENT;
        end else if (dac_wen && reg_wdata[DAC_VALID_BIT] && mode_ok) begin
            cur_cmd   <= reg_wdata[CMD_W-1:0];
            ctrl_mode <= wr_mode;
        end
    end

    // amp disable, kept inverted like the enable request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_disable <= 1'b1;
        end else if (dac_wen) begin
            reg_disable <= ~pwr_enable | safety_cond |
                           (reg_wdata[DAC_EN_MASK_BIT] ? ~reg_wdata[DAC_EN_BIT] : reg_disable);
        end else begin
            reg_disable <= reg_disable | safety_cond; // watchdog or trip forces off
        end
    end

    // config and current limit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            config_reg <= CONFIG_RST;
            safety_reg <= SAFETY_RST;
        end else begin
            if (cfg_wen)  config_reg <= reg_wdata[CFG_WR_W-1:0];
            if (safe_wen) safety_reg <= reg_wdata;
        end
    end

    assign cur_ctrl      = ~(ioexp_present && (ctrl_mode == MODE_VOLTAGE));
    assign amp_disable_f = ~config_reg[CFG_FORCE_F_BIT] & reg_disable;
    assign amp_fault_fb  = ~(reg_disable | amp_fault); // enabled but amp reports fault

    // readback words
    assign cfg    = {6'd0, ioexp_present, 1'b1, config_reg}; // bit 24 current ctrl available
    assign safety = safety_reg;
    assign status = {1'b0,            // 31
                     1'b0,            // 30 no dqla error path
                     amp_fault,       // 29
                     ~reg_disable,    // 28 enabled
                     ctrl_mode,       // 27:24
                     3'd0,
                     cur_ctrl,        // 20
                     2'd0,
                     safety_disable,  // 17
                     amp_fault_fb,    // 16
                     cur_cmd};        // 15:0

    overcurrent_check #(
        .TRIP_CYCLES (TRIP_CYCLES)
    ) overcurrent_check_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .cur_fb         (cur_fb),
        .cur_cmd        (cur_cmd),
        .cur_lim        (safety_reg[CMD_W-1:0]),
        .ctrl_mode      (ctrl_mode),
        .enable_check   (~config_reg[CFG_SAFETY_OFF_BIT]),
        .clear_disable  (en_req),
        .safety_disable (safety_disable)
    );

    amp_enable_delay #(
        .TICK_DIV (TICK_DIV)
    ) amp_enable_delay_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .amp_disable     (reg_disable),
        .delay           (config_reg[DELAY_W-1:0]),
        .bypass          (~ioexp_present),
        .amp_disable_pin (amp_disable_pin)
    );

endmodule

//--- logic/motor_reg_slave.sv
// motor_reg_slave: wishbone classic slave, channel decode, write strobes, read data mux
`timescale 1ns/1ps

module motor_reg_slave
    import motor_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                             clk,
    input  logic                             arst_n,

    // wishbone classic
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [WB_ADR_W-1:0]              wb_adr,
    input  logic [WB_DAT_W-1:0]              wb_dat_w,
    output logic [WB_DAT_W-1:0]              wb_dat_r,
    output logic                             wb_ack,

    // towards the channels
    output logic [NUM_CHANNELS-1:0]          ch_wen,    // one strobe per channel
    output logic [3:0]                       reg_off,   // shared offset
    output logic [WB_DAT_W-1:0]              reg_wdata, // shared write data
    input  logic [NUM_CHANNELS*WB_DAT_W-1:0] ch_status,
    input  logic [NUM_CHANNELS*WB_DAT_W-1:0] ch_config,
    input  logic [NUM_CHANNELS*WB_DAT_W-1:0] ch_safety
);

    localparam int CH_W = CH_SEL_MSB - CH_SEL_LSB + 1;

    logic [CH_W-1:0]     ch_sel;  // addressed channel
    logic [3:0]          off;     // offset inside the window
    logic                req;     // new access, not yet acked
    logic [WB_DAT_W-1:0] rd_word; // selected read word

    assign ch_sel   = wb_adr[CH_SEL_MSB:CH_SEL_LSB];
    assign off      = wb_adr[CH_SEL_LSB-1:0];
    assign req      = wb_cyc & wb_stb & ~wb_ack; // drops while ack is high

    assign reg_off   = off;
    assign reg_wdata = wb_dat_w;

    // write strobe lands on the same edge that raises ack
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_wen
        assign ch_wen[i] = req & wb_we & (ch_sel == CH_W'(i)); // out of range gets no strobe
    end

    // read word from the addressed channel
    always_comb begin
        rd_word = '0; // unmapped reads give 0
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (ch_sel == CH_W'(i)) begin
                case (off)
                    OFF_MOTOR_STATUS: rd_word = ch_status[i*WB_DAT_W +: WB_DAT_W];
                    OFF_MOTOR_CONFIG: rd_word = ch_config[i*WB_DAT_W +: WB_DAT_W];
                    OFF_MOTOR_SAFETY: rd_word = ch_safety[i*WB_DAT_W +: WB_DAT_W];
                    default:          rd_word = '0;
                endcase
            end
        end
    end

    // one cycle ack with the read data registered next to it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            wb_ack <= req;
            if (req) begin
                wb_dat_r <= wb_we ? '0 : rd_word; // sampled before the ack edge
            end
        end
    end

endmodule

//--- logic/motor_ctrl_top.sv
// motor_ctrl_top: register slave and the array of motor channels
`timescale 1ns/1ps

module motor_ctrl_top
    import motor_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,  // 1 to 16
    parameter int TICK_DIV     = 4,  // clk cycles per delay tick
    parameter int TRIP_CYCLES  = 8   // overcurrent persistence
) (
    input  logic                          clk,
    input  logic                          arst_n,

    // host bus
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [WB_ADR_W-1:0]           wb_adr,
    input  logic [WB_DAT_W-1:0]           wb_dat_w,
    output logic [WB_DAT_W-1:0]           wb_dat_r,
    output logic                          wb_ack,

    // board inputs
    input  logic                          ioexp_present,
    input  logic                          pwr_enable,
    input  logic                          wdog_timeout,
    input  logic [NUM_CHANNELS-1:0]       amp_fault,
    input  logic [NUM_CHANNELS*CMD_W-1:0] cur_fb,

    // amplifier outputs
    output logic [NUM_CHANNELS-1:0]       amp_disable_pin,
    output logic [NUM_CHANNELS-1:0]       amp_disable_f,
    output logic [NUM_CHANNELS-1:0]       cur_ctrl,
    output logic [NUM_CHANNELS*CMD_W-1:0] cur_cmd
);

    logic [NUM_CHANNELS-1:0]          ch_wen;
    logic [3:0]                       reg_off;
    logic [WB_DAT_W-1:0]              reg_wdata;
    logic [NUM_CHANNELS*WB_DAT_W-1:0] ch_status;
    logic [NUM_CHANNELS*WB_DAT_W-1:0] ch_config;
    logic [NUM_CHANNELS*WB_DAT_W-1:0] ch_safety;

    motor_reg_slave #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) motor_reg_slave_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .ch_wen    (ch_wen),
        .reg_off   (reg_off),
        .reg_wdata (reg_wdata),
        .ch_status (ch_status),
        .ch_config (ch_config),
        .ch_safety (ch_safety)
    );

    // one channel per amplifier, all on the shared write bus
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_ch
        motor_channel #(
            .TICK_DIV    (TICK_DIV),
            .TRIP_CYCLES (TRIP_CYCLES)
        ) motor_channel_i (
            .clk             (clk),
            .arst_n          (arst_n),
            .wen             (ch_wen[i]),
            .reg_off         (reg_off),
            .reg_wdata       (reg_wdata),
            .status          (ch_status[i*WB_DAT_W +: WB_DAT_W]),
            .cfg             (ch_config[i*WB_DAT_W +: WB_DAT_W]),
            .safety          (ch_safety[i*WB_DAT_W +: WB_DAT_W]),
            .ioexp_present   (ioexp_present),
            .pwr_enable      (pwr_enable),
            .wdog_timeout    (wdog_timeout),
            .amp_fault       (amp_fault[i]),
            .cur_fb          (cur_fb[i*CMD_W +: CMD_W]),
            .amp_disable_pin (amp_disable_pin[i]),
            .amp_disable_f   (amp_disable_f[i]),
            .cur_ctrl        (cur_ctrl[i]),
            .cur_cmd         (cur_cmd[i*CMD_W +: CMD_W])
        );
    end

endmodule

//--- dv/motor_ctrl_tb.sv
// motor_ctrl_tb: clock, reset, wishbone tasks, stimulus, checks, watchdog and result
`timescale 1ns/1ps

module motor_ctrl_tb
    import motor_pkg::*;
();

    localparam int NUM_CH      = 4;
    localparam int TICK_DIV    = 4;
    localparam int TRIP_CYCLES = 8;
    localparam int CLK_PERIOD  = 100;
    localparam int NUM_TESTS   = 6;
    // worst case per test is a full 255 tick delay plus bus traffic
    localparam longint WATCHDOG_NS = NUM_TESTS * (255 * TICK_DIV + 200) * CLK_PERIOD;

    logic                    clk;
    logic                    arst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [WB_ADR_W-1:0]     wb_adr;
    logic [WB_DAT_W-1:0]     wb_dat_w;
    logic [WB_DAT_W-1:0]     wb_dat_r;
    logic                    wb_ack;
    logic                    ioexp_present;
    logic                    pwr_enable;
    logic                    wdog_timeout;
    logic [NUM_CH-1:0]       amp_fault;
    logic [NUM_CH*CMD_W-1:0] cur_fb;
    logic [NUM_CH-1:0]       amp_disable_pin;
    logic [NUM_CH-1:0]       amp_disable_f;
    logic [NUM_CH-1:0]       cur_ctrl;
    logic [NUM_CH*CMD_W-1:0] cur_cmd;

    logic [15:0] exp_cmd [NUM_CH];  // model of the accepted setpoint
    logic [3:0]  exp_mode [NUM_CH]; // model of the accepted mode
    logic        ack_q = 1'b0;

    motor_ctrl_top #(
        .NUM_CHANNELS (NUM_CH),
        .TICK_DIV     (TICK_DIV),
        .TRIP_CYCLES  (TRIP_CYCLES)
    ) motor_ctrl_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string msg);
        abort_run($sformatf("FAILED at %0t ns: %s", $time, msg));
    endtask

    // dac control word built from its fields
    function automatic logic [31:0] dac_word(input logic valid, input logic en_mask,
                                             input logic en, input logic [3:0] mode,
                                             input logic [15:0] cmd);
        return {valid, 1'b0, en_mask, en, mode, 8'd0, cmd};
    endfunction

    // one classic cycle held until ack
    // entered 10 ns after a rising edge
    task automatic bus_cycle(input logic we, input int ch, input logic [3:0] off,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = {4'(ch), off};
        wb_dat_w = wdat;
        do begin
            @(posedge clk);
            #10;
            waited++;
            if (waited > 8) abort_run("no wishbone ack within 8 cycles");
        end while (!wb_ack);
        rdat   = wb_dat_r; // valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input int ch, input logic [3:0] off, input logic [31:0] d);
        logic [31:0] unused;
        bus_cycle(1'b1, ch, off, d, unused);
    endtask

    task automatic read_reg(input int ch, input logic [3:0] off, output logic [31:0] d);
        bus_cycle(1'b0, ch, off, '0, d);
    endtask

    task automatic set_fb(input int ch, input logic [15:0] v);
        cur_fb[ch*CMD_W +: CMD_W] = v;
    endtask

    // setpoint, mode and control type against the model on port and in status
    task automatic check_status(input int ch);
        logic [31:0] rd;
        logic        exp_ctrl;
        exp_ctrl = !(ioexp_present && exp_mode[ch] == MODE_VOLTAGE);
        read_reg(ch, OFF_MOTOR_STATUS, rd);
        assert (cur_cmd[ch*CMD_W +: CMD_W] == exp_cmd[ch])
            else flag_mismatch($sformatf("ch%0d cur_cmd %h, expected %h", ch,
                                         cur_cmd[ch*CMD_W +: CMD_W], exp_cmd[ch]));
        assert (rd[15:0] == exp_cmd[ch] && rd[27:24] == exp_mode[ch])
            else flag_mismatch($sformatf("ch%0d status %h, cmd %h mode %0d expected", ch,
                                         rd, exp_cmd[ch], exp_mode[ch]));
        assert (rd[20] == exp_ctrl && cur_ctrl[ch] == exp_ctrl)
            else flag_mismatch($sformatf("ch%0d cur_ctrl wrong, expected %b", ch, exp_ctrl));
    endtask

    // edges counted from the ack edge until the pin drops
    task automatic wait_pin_fall(input int ch, input int limit, output int n);
        n = 0;
        while (amp_disable_pin[ch]) begin
            @(posedge clk);
            #10;
            n++;
            if (n > limit) flag_mismatch($sformatf("ch%0d pin still high after %0d", ch, n));
        end
    endtask

    // ack is a single cycle pulse
    always @(negedge clk) begin
        if (arst_n) begin
            assert (!(wb_ack && ack_q)) else flag_mismatch("wb_ack high two cycles in a row");
        end
        ack_q = wb_ack;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the test sequence finished");
    end

    initial begin
        int          ch;
        int          ch_b;
        int          delay;
        int          n;
        logic [15:0] cmd;
        logic [31:0] rd;
        logic [31:0] cfg_wr;
        logic [31:0] snap_cfg;
        logic [31:0] snap_safe;
        logic [31:0] snap_stat;

        void'($urandom(32'hf7e5));
        arst_n        = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        ioexp_present = 1'b1;
        pwr_enable    = 1'b1;
        wdog_timeout  = 1'b0;
        amp_fault     = '1;  // all amps healthy
        cur_fb        = {NUM_CH{16'h8000}};
        for (int i = 0; i < NUM_CH; i++) begin
            exp_cmd[i]  = 16'h8000;
            exp_mode[i] = MODE_CURRENT;
        end
        repeat (3) @(posedge clk);
        #10;
        arst_n = 1'b1;

        // reset state
        assert (!wb_ack && &amp_disable_pin && &amp_disable_f && &cur_ctrl)
            else flag_mismatch("outputs not at reset values");
        read_reg(0, OFF_MOTOR_STATUS, rd);
        assert (rd[17] == 1'b0 && rd[28] == 1'b0) else flag_mismatch("status after reset");

        // setpoint write then ignored writes
        ch  = $urandom_range(NUM_CH - 1);
        cmd = 16'($urandom);
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b1, 1'b0, 1'b0, MODE_CURRENT, cmd));
        exp_cmd[ch] = cmd;
        set_fb(ch, cmd);
        check_status(ch);
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b0, 1'b0, MODE_CURRENT, ~cmd));
        check_status(ch);
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b1, 1'b0, 1'b0, 4'd5, ~cmd));
        check_status(ch);

        // voltage mode needs the io expander
        ioexp_present = 1'b0;
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b1, 1'b0, 1'b0, MODE_VOLTAGE, ~cmd));
        check_status(ch);
        ioexp_present = 1'b1;
        cmd = 16'($urandom);
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b1, 1'b0, 1'b0, MODE_VOLTAGE, cmd));
        exp_cmd[ch]  = cmd;
        exp_mode[ch] = MODE_VOLTAGE;
        set_fb(ch, cmd);
        check_status(ch);
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b1, 1'b0, 1'b0, MODE_CURRENT, cmd));
        exp_mode[ch] = MODE_CURRENT;
        check_status(ch);

        // enable delay on a random channel with a random tick count
        repeat (3) begin
            ch    = $urandom_range(NUM_CH - 1);
            delay = $urandom_range(12, 1);
            write_reg(ch, OFF_MOTOR_CONFIG, 32'(delay));
            write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b1, MODE_CURRENT, 16'd0));
            wait_pin_fall(ch, delay * TICK_DIV + TICK_DIV, n);
            assert (n >= delay * TICK_DIV - TICK_DIV)
                else flag_mismatch($sformatf("pin fell after %0d cycles, delay %0d", n, delay));
            read_reg(ch, OFF_MOTOR_STATUS, rd);
            assert (rd[28]) else flag_mismatch("enabled bit not set");
            write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b0, MODE_CURRENT, 16'd0));
            assert (amp_disable_pin[ch]) else flag_mismatch("pin not high at disable ack");
        end
        ioexp_present = 1'b0;  // without the follower the pin tracks the enable directly
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b1, MODE_CURRENT, 16'd0));
        assert (!amp_disable_pin[ch]) else flag_mismatch("bypassed pin not low at ack");
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b0, MODE_CURRENT, 16'd0));
        assert (amp_disable_pin[ch]) else flag_mismatch("bypassed pin not high at ack");
        ioexp_present = 1'b1;

        // overcurrent trip and clear
        ch = $urandom_range(NUM_CH - 1);
        write_reg(ch, OFF_MOTOR_SAFETY, 32'h0000_0100);
        write_reg(ch, OFF_MOTOR_CONFIG, 32'd2);
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b1, MODE_CURRENT, 16'd0));
        wait_pin_fall(ch, 3 * TICK_DIV, n);
        set_fb(ch, exp_cmd[ch] + 16'h0180);
        n = 0;
        while (!amp_disable_pin[ch]) begin
            @(posedge clk);
            #10;
            n++;
            if (n > TRIP_CYCLES + 4) flag_mismatch("overcurrent did not trip");
        end
        assert (n >= TRIP_CYCLES) else flag_mismatch($sformatf("trip after only %0d", n));
        read_reg(ch, OFF_MOTOR_STATUS, rd);
        assert (rd[17] && !rd[28]) else flag_mismatch($sformatf("status after trip %h", rd));
        set_fb(ch, exp_cmd[ch]);
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b1, MODE_CURRENT, 16'd0));
        read_reg(ch, OFF_MOTOR_STATUS, rd);
        assert (!rd[17]) else flag_mismatch("trip not cleared by enable write");
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b1, MODE_CURRENT, 16'd0));
        wait_pin_fall(ch, 3 * TICK_DIV, n);
        write_reg(ch, OFF_MOTOR_CONFIG, 32'h0002_0002); // safety check off
        set_fb(ch, exp_cmd[ch] + 16'h0180);
        repeat (3 * TRIP_CYCLES) begin
            @(posedge clk);
            #10;
            assert (!amp_disable_pin[ch]) else flag_mismatch("trip with safety disabled");
        end
        read_reg(ch, OFF_MOTOR_STATUS, rd);
        assert (!rd[17]) else flag_mismatch("safety bit set with check disabled");
        set_fb(ch, exp_cmd[ch]);

        // watchdog and power
        ch = $urandom_range(NUM_CH - 1);
        write_reg(ch, OFF_MOTOR_CONFIG, 32'd3);
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b1, MODE_CURRENT, 16'd0));
        wait_pin_fall(ch, 4 * TICK_DIV, n);
        wdog_timeout = 1'b1;
        @(posedge clk);
        #10;
        wdog_timeout = 1'b0;
        read_reg(ch, OFF_MOTOR_STATUS, rd);
        assert (!rd[28] && amp_disable_pin[ch]) else flag_mismatch("watchdog left amp enabled");
        pwr_enable = 1'b0;
        write_reg(ch, OFF_DAC_CTRL, dac_word(1'b0, 1'b1, 1'b1, MODE_CURRENT, 16'd0));
        read_reg(ch, OFF_MOTOR_STATUS, rd);
        assert (!rd[28] && amp_disable_pin[ch]) else flag_mismatch("enabled without power");
        pwr_enable = 1'b1;

        // config readback and force_disable_f, then writes that must not land
        ch     = $urandom_range(NUM_CH - 1);
        ch_b   = (ch + 1) % NUM_CH;
        cfg_wr = {8'd0, 24'($urandom)} | 32'h0001_0000;
        write_reg(ch, OFF_MOTOR_CONFIG, cfg_wr | 32'hff00_0000); // top byte is read only
        read_reg(ch, OFF_MOTOR_CONFIG, rd);
        assert (rd == {6'd0, 1'b1, 1'b1, cfg_wr[23:0]})
            else flag_mismatch($sformatf("config readback %h", rd));
        assert (!amp_disable_f[ch]) else flag_mismatch("force_disable_f ignored");
        cfg_wr[16] = 1'b0;
        write_reg(ch, OFF_MOTOR_CONFIG, cfg_wr);
        assert (amp_disable_f[ch]) else flag_mismatch("amp_disable_f low while disabled");
        ioexp_present = 1'b0;
        read_reg(ch, OFF_MOTOR_CONFIG, rd);
        assert (rd == {6'd0, 1'b0, 1'b1, cfg_wr[23:0]}) else flag_mismatch("config bit 25");
        ioexp_present = 1'b1;
        read_reg(ch, OFF_MOTOR_CONFIG, snap_cfg);
        read_reg(ch, OFF_MOTOR_SAFETY, snap_safe);
        read_reg(ch, OFF_MOTOR_STATUS, snap_stat);
        write_reg(ch_b, OFF_MOTOR_CONFIG, ~cfg_wr);
        write_reg(ch, 4'd7, 32'hffff_ffff);
        // out of range channel whose low bits alias the one under test
        if (NUM_CH + ch < 16) write_reg(NUM_CH + ch, OFF_MOTOR_CONFIG, 32'h00ff_ffff);
        read_reg(ch, OFF_MOTOR_CONFIG, rd);
        assert (rd == snap_cfg) else flag_mismatch("config changed by a foreign write");
        read_reg(ch, OFF_MOTOR_SAFETY, rd);
        assert (rd == snap_safe) else flag_mismatch("limit changed by a foreign write");
        read_reg(ch, OFF_MOTOR_STATUS, rd);
        assert (rd == snap_stat) else flag_mismatch("status changed by a foreign write");
        read_reg(ch, 4'd7, rd);
        assert (rd == '0) else flag_mismatch("unmapped offset read not zero");

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- flist.f
logic/motor_pkg.sv
logic/overcurrent_check.sv
logic/amp_enable_delay.sv
logic/motor_channel.sv
logic/motor_reg_slave.sv
logic/motor_ctrl_top.sv
dv/motor_ctrl_tb.sv

//--- Bender.yml
package:
  name: motor_ctrl

sources:
  - logic/motor_pkg.sv
  - logic/overcurrent_check.sv
  - logic/amp_enable_delay.sv
  - logic/motor_channel.sv
  - logic/motor_reg_slave.sv
  - logic/motor_ctrl_top.sv
  - target: test
    files:
      - dv/motor_ctrl_tb.sv
